/* hdl/c16_pkg.sv */
// Shared types and constants for the c16 core
// Halfword and memory word types, register numbers
// Instruction field positions and opcodes
// Lane structs for issue, write-back and the fetch window
// APB address map

`default_nettype none

package c16_pkg;

   typedef logic [15:0] word_t;
   // Low half executes first
   typedef logic [31:0] mem_word_t;
   typedef logic [2:0]  reg_addr_t;

   localparam int        NUM_REGS = 8;
   localparam reg_addr_t ZERO_REG = 3'd7;

   //////////////////////////////////////////////////
   // Instruction fields
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 11;
   localparam int RD_HI  = 10;
   localparam int RD_LO  = 8;
   localparam int RS0_HI = 7;
   localparam int RS0_LO = 5;
   localparam int RS1_HI = 2;
   localparam int RS1_LO = 0;
   localparam int IMM_HI = 4;
   localparam int IMM_LO = 0;

   typedef enum logic [4:0] {
      op_add_imm = 5'd0,
      op_add_reg = 5'd1,
      op_sub_imm = 5'd2,
      op_sub_reg = 5'd3,
      op_halt    = 5'd31
   } opcode_e;

   // Zero encoding is the idle lane
   typedef enum logic [1:0] {
      alu_nop = 2'd0,
      alu_add = 2'd1,
      alu_sub = 2'd2
   } alu_op_e;

   // One lane from decode to execute
   typedef struct packed {
      alu_op_e   op;
      reg_addr_t rd;
      word_t     arg0;
      word_t     arg1;
   } issue_t;

   // One lane from execute to the register file
   typedef struct packed {
      logic      we;
      reg_addr_t addr;
      word_t     value;
   } wb_t;

   // Next two halfwords in program order
   typedef struct packed {
      word_t first;
      word_t second;
      logic  valid;
   } window_t;

   // Number of halfwords decode takes per cycle
   typedef logic [1:0] consume_t;

   //////////////////////////////////////////////////
   // APB map in byte addresses
   localparam logic [11:0] IMEM_BASE = 12'h000;
   localparam logic [11:0] REG_BASE  = 12'h100;
   localparam logic [11:0] CTRL_ADDR = 12'h200;

endpackage

`default_nettype wire

/* hdl/c16_imem.sv */
// Instruction memory of the c16 core
// Registered read port for fetch, write port for loading

`timescale 1ns/1ps
`default_nettype none

module c16_imem #(
   parameter int IMEM_WORDS = 64
) (
   input  wire                            clk,
   input  wire [$clog2(IMEM_WORDS)-1:0]   raddr,
   input  wire                            we,
   input  wire [$clog2(IMEM_WORDS)-1:0]   waddr,
   input  wire c16_pkg::mem_word_t        wdata,
   output c16_pkg::mem_word_t             rdata
);

   import c16_pkg::*;

   mem_word_t mem [IMEM_WORDS];

   // Read returns the old word on a same-address write
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

endmodule

`default_nettype wire

/* hdl/c16_apb_ctrl.sv */
// APB slave of the c16 core
// Address decode for memory, registers and control
// Running and halted flags, start pulse
// Memory write path and register read path

`timescale 1ns/1ps
`default_nettype none

module c16_apb_ctrl #(
   parameter int IMEM_WORDS = 64
) (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            psel,
   input  wire                            penable,
   input  wire                            pwrite,
   input  wire [11:0]                     paddr,
   input  wire [31:0]                     pwdata,
   input  wire                            halt_seen,
   input  wire c16_pkg::word_t            dbg_value,
   output logic [31:0]                    prdata,
   output logic                           pready,
   output logic                           running,
   output logic                           start,
   output logic                           imem_we,
   output logic [$clog2(IMEM_WORDS)-1:0]  imem_waddr,
   output c16_pkg::mem_word_t             imem_wdata,
   output c16_pkg::reg_addr_t             dbg_addr
);

   import c16_pkg::*;

   localparam int AW = $clog2(IMEM_WORDS);

   logic access;
   logic sel_imem;
   logic sel_reg;
   logic sel_ctrl;
   logic ctrl_wr;
   logic halted;

   //////////////////////////////////////////////////
   // Address decode, access phase only
   assign access   = psel && penable;
   assign sel_imem = paddr[11:8] == IMEM_BASE[11:8];
   assign sel_reg  = paddr[11:8] == REG_BASE[11:8];
   assign sel_ctrl = paddr == CTRL_ADDR;
   assign ctrl_wr  = access && pwrite && sel_ctrl;

   // Zero wait states
   assign pready = 1'b1;

   assign imem_we    = access && pwrite && sel_imem;
   assign imem_waddr = paddr[AW+1:2];
   assign imem_wdata = pwdata;

   // One register every 4 bytes
   assign dbg_addr = paddr[4:2];
   assign start    = ctrl_wr && pwdata[0];

   //////////////////////////////////////////////////
   // Run state
   always_ff @(posedge clk) begin
      if (reset) begin
         running <= 1'b0;
         halted  <= 1'b0;
      end else if (ctrl_wr) begin
         running <= pwdata[0];
         if (pwdata[0]) begin
            halted <= 1'b0;
         end
      end else if (halt_seen) begin
         running <= 1'b0;
         halted  <= 1'b1;
      end
   end

   // Memory space reads back as zero
   always_comb begin
      prdata = '0;
      if (access && !pwrite) begin
         if (sel_reg) begin
            prdata = {16'h0000, dbg_value};
         end else if (sel_ctrl) begin
            prdata = {30'h0, halted, running};
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/c16_fetch.sv */
// Fetch stage of the c16 core
// Program counter with wrap at the memory size
// Two-entry halfword buffer and the pair window
// Stall when the buffer cannot take the memory word

`timescale 1ns/1ps
`default_nettype none

module c16_fetch #(
   parameter int IMEM_WORDS = 64
) (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            running,
   input  wire                            start,
   input  wire c16_pkg::mem_word_t        rdata,
   input  wire c16_pkg::consume_t         consume,
   output logic [$clog2(IMEM_WORDS)-1:0]  raddr,
   output c16_pkg::window_t               window
);

   import c16_pkg::*;

   localparam int AW = $clog2(IMEM_WORDS);

   // Address of the word now on rdata
   logic [AW-1:0] pc;
   logic          word_valid;
   logic [1:0]    count;
   word_t         hw_buf [2];
   word_t         seq [4];
   logic [2:0]    avail;
   logic [2:0]    keep;
   logic          stall;

   // Buffered halfwords first, then the memory word low half first
   always_comb begin
      seq[0] = hw_buf[0];
      seq[1] = hw_buf[1];
      seq[2] = rdata[15:0];
      seq[3] = rdata[31:16];
      if (count == 2'd1) begin
         seq[1] = rdata[15:0];
         seq[2] = rdata[31:16];
      end else if (count == 2'd0) begin
         seq[0] = rdata[15:0];
         seq[1] = rdata[31:16];
      end
   end

   assign avail = {1'b0, count} + (word_valid ? 3'd2 : 3'd0);

   assign window.first  = seq[0];
   assign window.second = seq[1];
   assign window.valid  = avail >= 3'd2;

   // Only a full buffer with one halfword taken leaves three
   assign stall = word_valid && (count > consume);
   assign keep  = (stall ? {1'b0, count} : avail) - {1'b0, consume};

   always_comb begin
      if (start) begin
         raddr = '0;
      end else if (running && !stall) begin
         raddr = pc + AW'(1);
      end else begin
         raddr = pc;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc         <= '0;
         word_valid <= 1'b0;
         count      <= 2'd0;
      end else begin
         pc         <= raddr;
         word_valid <= start || (running && word_valid);
         if (start) begin
            count <= 2'd0;
         end else if (running) begin
            count <= keep[1:0];
         end
      end
   end

   // Leftovers shift down by the consumed count
   always_ff @(posedge clk) begin
      if (running) begin
         hw_buf[0] <= seq[consume];
         hw_buf[1] <= seq[consume + 2'd1];
      end
   end

endmodule

`default_nettype wire

/* hdl/c16_decode.sv */
// Decode stage of the c16 core
// Field extraction and opcode to ALU op mapping
// Pair hazard check and halt detection
// Registered issue of two lanes

`timescale 1ns/1ps
`default_nettype none

module c16_decode (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      running,
   input  wire c16_pkg::window_t    window,
   input  wire c16_pkg::word_t      rv_a0,
   input  wire c16_pkg::word_t      rv_a1,
   input  wire c16_pkg::word_t      rv_b0,
   input  wire c16_pkg::word_t      rv_b1,
   output c16_pkg::consume_t        consume,
   output logic                     halt_seen,
   output c16_pkg::reg_addr_t       ra_a0,
   output c16_pkg::reg_addr_t       ra_a1,
   output c16_pkg::reg_addr_t       ra_b0,
   output c16_pkg::reg_addr_t       ra_b1,
   output c16_pkg::issue_t          lane_a,
   output c16_pkg::issue_t          lane_b
);

   import c16_pkg::*;

   localparam issue_t IDLE = '{op: alu_nop, rd: '0, arg0: '0, arg1: '0};

   word_t     first;
   word_t     second;
   reg_addr_t rd_a;
   logic      go;
   logic      halt_a;
   logic      hazard;
   logic      cancel_b;
   issue_t    issue_a;
   issue_t    issue_b;

   // Add or sub that really writes; the zero word is a no-op
   function automatic logic is_alu(word_t inst);
      opcode_e opc;
      opc = opcode_e'(inst[OPC_HI:OPC_LO]);
      return (inst != '0) && (opc inside {op_add_imm, op_add_reg, op_sub_imm, op_sub_reg});
   endfunction

   function automatic logic is_reg_form(word_t inst);
      opcode_e opc;
      opc = opcode_e'(inst[OPC_HI:OPC_LO]);
      return (opc == op_add_reg) || (opc == op_sub_reg);
   endfunction

   function automatic issue_t slot_issue(word_t inst, word_t v0, word_t v1);
      issue_t iss;
      iss.op   = alu_nop;
      iss.rd   = inst[RD_HI:RD_LO];
      iss.arg0 = v0;
      // Sign-extended imm5
      iss.arg1 = {{11{inst[IMM_HI]}}, inst[IMM_HI:IMM_LO]};
      if (is_alu(inst)) begin
         iss.op = (inst[OPC_HI:OPC_LO] == op_sub_imm || inst[OPC_HI:OPC_LO] == op_sub_reg)
                  ? alu_sub : alu_add;
         if (is_reg_form(inst)) begin
            iss.arg1 = v1;
         end
      end
      return iss;
   endfunction

   assign first  = window.first;
   assign second = window.second;

   assign ra_a0 = first[RS0_HI:RS0_LO];
   assign ra_a1 = first[RS1_HI:RS1_LO];
   assign ra_b0 = second[RS0_HI:RS0_LO];
   assign ra_b1 = second[RS1_HI:RS1_LO];

   //////////////////////////////////////////////////
   // Pair check
   assign rd_a   = first[RD_HI:RD_LO];
   assign go     = running && window.valid;
   assign halt_a = first[OPC_HI:OPC_LO] == op_halt;
   assign hazard = is_alu(first) && is_alu(second) &&
                   (rd_a == ra_b0 || (is_reg_form(second) && rd_a == ra_b1));
   // second slot waits and leads the next pair
   assign cancel_b = hazard || (second[OPC_HI:OPC_LO] == op_halt);

   assign halt_seen = go && halt_a;

   always_comb begin
      issue_a = IDLE;
      issue_b = IDLE;
      consume = 2'd0;
      if (go) begin
         consume = (halt_a || cancel_b) ? 2'd1 : 2'd2;
         if (!halt_a) begin
            issue_a = slot_issue(first, rv_a0, rv_a1);
            if (!cancel_b) begin
               issue_b = slot_issue(second, rv_b0, rv_b1);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         lane_a <= IDLE;
         lane_b <= IDLE;
      end else begin
         lane_a <= issue_a;
         lane_b <= issue_b;
      end
   end

endmodule

`default_nettype wire

/* hdl/c16_execute.sv */
// Execute stage of the c16 core
// Two add/sub lanes producing register write-backs

`timescale 1ns/1ps
`default_nettype none

module c16_execute (
   input  wire c16_pkg::issue_t  lane_a,
   input  wire c16_pkg::issue_t  lane_b,
   output c16_pkg::wb_t          wb_a,
   output c16_pkg::wb_t          wb_b
);

   import c16_pkg::*;

   function automatic wb_t run_lane(issue_t lane);
      wb_t wb;
      wb.addr = lane.rd;
      case (lane.op)
         alu_add: wb.value = lane.arg0 + lane.arg1;
         alu_sub: wb.value = lane.arg0 - lane.arg1;
         default: wb.value = '0;
      endcase
      // Register 7 stays zero
      wb.we = (lane.op != alu_nop) && (lane.rd != ZERO_REG);
      return wb;
   endfunction

   assign wb_a = run_lane(lane_a);
   assign wb_b = run_lane(lane_b);

endmodule

`default_nettype wire

/* hdl/c16_regfile.sv */
// Register file of the c16 core
// Eight registers, two write ports
// Four operand read ports and one debug read port
// Same-cycle bypass of write-back values

`timescale 1ns/1ps
`default_nettype none

module c16_regfile (
   input  wire                      clk,
   input  wire                      reset,
   input  wire c16_pkg::reg_addr_t  ra_a0,
   input  wire c16_pkg::reg_addr_t  ra_a1,
   input  wire c16_pkg::reg_addr_t  ra_b0,
   input  wire c16_pkg::reg_addr_t  ra_b1,
   input  wire c16_pkg::reg_addr_t  dbg_addr,
   input  wire c16_pkg::wb_t        wb_a,
   input  wire c16_pkg::wb_t        wb_b,
   output c16_pkg::word_t           rv_a0,
   output c16_pkg::word_t           rv_a1,
   output c16_pkg::word_t           rv_b0,
   output c16_pkg::word_t           rv_b1,
   output c16_pkg::word_t           dbg_value
);

   import c16_pkg::*;

   word_t regs [NUM_REGS];

   // Lane b is later in program order and wins
   function automatic word_t read_port(reg_addr_t addr);
      word_t value;
      value = regs[addr];
      if (wb_a.we && wb_a.addr == addr) begin
         value = wb_a.value;
      end
      if (wb_b.we && wb_b.addr == addr) begin
         value = wb_b.value;
      end
      return value;
   endfunction

   assign rv_a0     = read_port(ra_a0);
   assign rv_a1     = read_port(ra_a1);
   assign rv_b0     = read_port(ra_b0);
   assign rv_b1     = read_port(ra_b1);
   assign dbg_value = read_port(dbg_addr);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wb_a.we) begin
            regs[wb_a.addr] <= wb_a.value;
         end
         if (wb_b.we) begin
            regs[wb_b.addr] <= wb_b.value;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/c16_top.sv */
// Top level of the dual-issue c16 core
// APB slave, instruction memory, fetch, decode,
// two-lane execute and register file

`timescale 1ns/1ps
`default_nettype none

module c16_top #(
   parameter int IMEM_WORDS = 64
) (
   input  wire        clk,
   input  wire        reset,
   input  wire        psel,
   input  wire        penable,
   input  wire        pwrite,
   input  wire [11:0] paddr,
   input  wire [31:0] pwdata,
   output wire [31:0] prdata,
   output wire        pready
);

   import c16_pkg::*;

   localparam int AW = $clog2(IMEM_WORDS);

   logic            running;
   logic            start;
   logic            halt_seen;

   // Memory load path and fetch path
   logic            imem_we;
   logic [AW-1:0]   imem_waddr;
   mem_word_t       imem_wdata;
   logic [AW-1:0]   raddr;
   mem_word_t       rdata;

   window_t         window;
   consume_t        consume;

   // Operand reads of both slots
   reg_addr_t       ra_a0;
   reg_addr_t       ra_a1;
   reg_addr_t       ra_b0;
   reg_addr_t       ra_b1;
   word_t           rv_a0;
   word_t           rv_a1;
   word_t           rv_b0;
   word_t           rv_b1;

   issue_t          lane_a;
   issue_t          lane_b;
   wb_t             wb_a;
   wb_t             wb_b;

   reg_addr_t       dbg_addr;
   word_t           dbg_value;

   c16_apb_ctrl #(.IMEM_WORDS(IMEM_WORDS)) u_apb_ctrl (
      .clk        (clk),
      .reset      (reset),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .halt_seen  (halt_seen),
      .dbg_value  (dbg_value),
      .prdata     (prdata),
      .pready     (pready),
      .running    (running),
      .start      (start),
      .imem_we    (imem_we),
      .imem_waddr (imem_waddr),
      .imem_wdata (imem_wdata),
      .dbg_addr   (dbg_addr)
   );

   c16_imem #(.IMEM_WORDS(IMEM_WORDS)) u_imem (
      .clk   (clk),
      .raddr (raddr),
      .we    (imem_we),
      .waddr (imem_waddr),
      .wdata (imem_wdata),
      .rdata (rdata)
   );

   c16_fetch #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
      .clk     (clk),
      .reset   (reset),
      .running (running),
      .start   (start),
      .rdata   (rdata),
      .consume (consume),
      .raddr   (raddr),
      .window  (window)
   );

   c16_decode u_decode (
      .clk       (clk),
      .reset     (reset),
      .running   (running),
      .window    (window),
      .rv_a0     (rv_a0),
      .rv_a1     (rv_a1),
      .rv_b0     (rv_b0),
      .rv_b1     (rv_b1),
      .consume   (consume),
      .halt_seen (halt_seen),
      .ra_a0     (ra_a0),
      .ra_a1     (ra_a1),
      .ra_b0     (ra_b0),
      .ra_b1     (ra_b1),
      .lane_a    (lane_a),
      .lane_b    (lane_b)
   );

   c16_execute u_execute (
      .lane_a (lane_a),
      .lane_b (lane_b),
      .wb_a   (wb_a),
      .wb_b   (wb_b)
   );

   c16_regfile u_regfile (
      .clk       (clk),
      .reset     (reset),
      .ra_a0     (ra_a0),
      .ra_a1     (ra_a1),
      .ra_b0     (ra_b0),
      .ra_b1     (ra_b1),
      .dbg_addr  (dbg_addr),
      .wb_a      (wb_a),
      .wb_b      (wb_b),
      .rv_a0     (rv_a0),
      .rv_a1     (rv_a1),
      .rv_b0     (rv_b0),
      .rv_b1     (rv_b1),
      .dbg_value (dbg_value)
   );

endmodule

`default_nettype wire

/* tb/c16_checker.sv */
// Checker for the c16 testbench
// Watches APB reads while checking is enabled
// Compares status and register reads with expected values
// Checks pready in every access phase
// Keeps counts of checked reads and errors

`timescale 1ns/1ps
`default_nettype none

module c16_checker (
   input  wire             clk,
   input  wire             check_en,
   input  wire             psel,
   input  wire             penable,
   input  wire             pwrite,
   input  wire [11:0]      paddr,
   input  wire [31:0]      prdata,
   input  wire             pready,
   input  wire [7:0][15:0] exp_regs,
   input  wire [31:0]      exp_status,
   output int              err_count,
   output int              check_count
);

   import c16_pkg::*;

   int          errors = 0;
   int          checks = 0;
   logic [2:0]  rnum;
   logic [31:0] expected;

   assign err_count   = errors;
   assign check_count = checks;

   // Sampled mid access phase, away from the driving edge
   always @(negedge clk) begin
      // Zero wait states on every transfer
      if (psel && penable && pready !== 1'b1) begin
         $display("mismatch pready: expected 0x1, got 0x%h", pready);
         errors = errors + 1;
      end
      if (check_en && psel && penable && !pwrite) begin
         checks = checks + 1;
         if (paddr == CTRL_ADDR) begin
            if (prdata !== exp_status) begin
               $display("mismatch status: expected 0x%08h, got 0x%08h",
                        exp_status, prdata);
               errors = errors + 1;
            end
         end else if (paddr[11:8] == REG_BASE[11:8]) begin
            rnum     = paddr[4:2];
            // Upper half of a register read is zero
            expected = {16'h0000, exp_regs[rnum]};
            if (prdata !== expected) begin
               $display("mismatch r%0d: expected 0x%08h, got 0x%08h",
                        rnum, expected, prdata);
               errors = errors + 1;
            end
         end else begin
            $display("unexpected read of address 0x%03h during a check", paddr);
            errors = errors + 1;
         end
      end
   end

endmodule

`default_nettype wire

/* tb/tb_c16.sv */
// Testbench top for the c16 core
// Clock and reset, case file reader, APB driver
// Per-case program load, run, status poll and register readback
// Watchdog sized from the number of cases

`timescale 1ns/1ps
`default_nettype none

module tb_c16;

   import c16_pkg::*;

   localparam int IMEM_WORDS = 64;
   localparam int MAX_CASES  = 32;
   localparam int POOL_WORDS = 1024;

   logic             clk;
   logic             reset;
   logic             psel;
   logic             penable;
   logic             pwrite;
   logic [11:0]      paddr;
   logic [31:0]      pwdata;
   logic [31:0]      prdata;
   logic             pready;

   // Expected values handed to the checker
   logic             check_en;
   logic [7:0][15:0] exp_regs;
   logic [31:0]      exp_status;
   int               err_count;
   int               check_count;

   // Case table filled from the file
   logic [8*24-1:0]  case_name [MAX_CASES];
   int               case_run [MAX_CASES];
   int               case_len [MAX_CASES];
   int               case_first [MAX_CASES];
   logic [7:0][15:0] case_regs [MAX_CASES];
   logic [31:0]      case_status [MAX_CASES];
   logic [31:0]      pool [POOL_WORDS];
   int               num_cases;
   int               pool_used;
   int               setup_errors;
   logic             parsed;

   c16_top #(.IMEM_WORDS(IMEM_WORDS)) uut (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready)
   );

   c16_checker u_checker (
      .clk         (clk),
      .check_en    (check_en),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .prdata      (prdata),
      .pready      (pready),
      .exp_regs    (exp_regs),
      .exp_status  (exp_status),
      .err_count   (err_count),
      .check_count (check_count)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Case file
   task automatic read_cases();
      int               fd;
      int               n;
      int               i;
      int               r;
      int               run;
      int               len;
      logic [31:0]      value;
      logic [8*24-1:0]  tok;
      logic [8*24-1:0]  name;
      logic [8*128-1:0] line;
      num_cases = 0;
      pool_used = 0;
      fd = $fopen("tb/c16_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open the case file tb/c16_cases.txt");
         setup_errors++;
         return;
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok == "#") begin
            n = $fgets(line, fd);
         end else if (tok == "case" && num_cases < MAX_CASES) begin
            n = $fscanf(fd, "%s %d %d", name, run, len);
            if (len > IMEM_WORDS || pool_used + len > POOL_WORDS) begin
               $display("case %0s has too many program words", name);
               setup_errors++;
            end
            case_name[num_cases]  = name;
            case_run[num_cases]   = run;
            case_len[num_cases]   = len;
            case_first[num_cases] = pool_used;
            for (i = 0; i < len; i++) begin
               n = $fscanf(fd, "%h", value);
               pool[pool_used] = value;
               pool_used++;
            end
         end else if (tok == "expect") begin
            for (r = 0; r < NUM_REGS; r++) begin
               n = $fscanf(fd, "%h", value);
               case_regs[num_cases][r] = value[15:0];
            end
            n = $fscanf(fd, "%h", value);
            case_status[num_cases] = value;
            num_cases++;
         end else begin
            $display("unexpected token %0s in the case file", tok);
            setup_errors++;
         end
      end
      $fclose(fd);
   endtask

   //////////////////////////////////////////////////
   // APB driver
   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // prdata sampled mid access phase
   task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data = prdata;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic run_case(input int c, output int errs);
      logic [31:0] data;
      int          err_before;
      int          chk_before;
      int          i;
      err_before = err_count;
      exp_regs   = case_regs[c];
      exp_status = case_status[c];
      if (case_run[c] != 0) begin
         // No words means the program already in memory runs again
         for (i = 0; i < case_len[c]; i++) begin
            apb_write(IMEM_BASE + 12'(4 * i), pool[case_first[c] + i]);
         end
         apb_write(CTRL_ADDR, 32'h1);
         do begin
            apb_read(CTRL_ADDR, data);
         end while (!data[1]);
      end
      chk_before = check_count;
      check_en   = 1'b1;
      apb_read(CTRL_ADDR, data);
      for (i = 0; i < NUM_REGS; i++) begin
         apb_read(REG_BASE + 12'(4 * i), data);
      end
      check_en = 1'b0;
      errs = err_count - err_before;
      if (check_count - chk_before != NUM_REGS + 1) begin
         $display("case %0s: checker saw %0d reads instead of %0d",
                  case_name[c], check_count - chk_before, NUM_REGS + 1);
         errs++;
      end
   endtask

   initial begin
      int c;
      int errs;
      int passed;
      int failed;
      reset        = 1'b1;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      check_en     = 1'b0;
      exp_regs     = '0;
      exp_status   = '0;
      setup_errors = 0;
      passed       = 0;
      failed       = 0;
      parsed       = 1'b0;
      read_cases();
      parsed = 1'b1;
      if (num_cases == 0) begin
         $display("no cases found in the case file");
      end
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      for (c = 0; c < num_cases; c++) begin
         run_case(c, errs);
         if (errs == 0) begin
            passed++;
            $display("case %0s: pass", case_name[c]);
         end else begin
            failed++;
            $display("case %0s: fail with %0d errors", case_name[c], errs);
         end
      end
      $display("cases %0d, passed %0d, failed %0d, mismatches %0d",
               num_cases, passed, failed, err_count);
      if (failed == 0 && setup_errors == 0 && num_cases > 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Each case gets four cycles per memory word
   initial begin
      wait (parsed === 1'b1);
      repeat (num_cases * IMEM_WORDS * 4 + 200) @(posedge clk);
      $display("timeout: the cases did not finish within %0d cycles",
               num_cases * IMEM_WORDS * 4 + 200);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/c16_cases.txt */
# case <name> <run> <words>, then <words> program words in hex, low half runs first
# expect <r0> <r1> <r2> <r3> <r4> <r5> <r6> <r7> <status>, all in hex
case after_reset 0 0
expect 0000 0000 0000 0000 0000 0000 0000 0000 00000000
# immediates with negative imm5, independent pairs
case imm_pairs 1 4
02FD01E5
14EF13F0
1642053F
0000F800
expect 0000 0005 FFFD 0010 FFF1 0004 FFFB 0000 00000002
# second slot reads first rd through rs0 and rs1
case dep_in_word 1 4
010300E7
0BE21221
1DE41C60
0000F800
expect 0007 000A 0009 0009 0002 FFFE FFFB 0000 00000002
# chains across pairs, buffer fills and fetch stalls
case cross_pair 1 7
02E201E1
0C410B22
19A30D64
16410224
0C0000CA
1D8303FF
0000F800
expect 0010 0003 0007 FFFF 0020 0021 0006 0000 00000002
# writes to r7, zero words and unknown opcodes
case no_effect 1 5
09E707E9
2A450000
1701F3E1
00000CE7
0000F800
expect 0010 0000 0007 FFFF 0000 0021 0006 0000 00000002
# halt in the second slot, then the same program again
case halt_second 1 2
02440123
F8000B22
expect 0010 0003 000B 000E 0000 0021 0006 0000 00000002
case restart 1 0
expect 0010 0006 000F 0015 0000 0021 0006 0000 00000002

/* sim.f */
hdl/c16_pkg.sv
hdl/c16_imem.sv
hdl/c16_apb_ctrl.sv
hdl/c16_fetch.sv
hdl/c16_decode.sv
hdl/c16_execute.sv
hdl/c16_regfile.sv
hdl/c16_top.sv
tb/c16_checker.sv
tb/tb_c16.sv

/* run.sh */
#!/bin/sh
# Build and run the c16 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_c16 --Mdir obj_dir -o sim_c16
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/sim_c16)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qxF '*** PASSED ***'; then
   exit 0
fi
exit 1
